//--- Bender.yml
package:
  name: game_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/game_pkg.sv
      - verilog/tick_divider.sv
      - verilog/game_fsm.sv
      - verilog/player_ctrl.sv
      - verilog/bullet_unit.sv
      - verilog/enemy_field.sv
      - verilog/status_digits.sv
      - verilog/game_top.sv
  - target: test
    include_dirs:
      - verilog
      - sim
    files:
      - sim/game_tb.sv

//--- project.f
+incdir+verilog
+incdir+sim
verilog/game_pkg.sv
verilog/tick_divider.sv
verilog/game_fsm.sv
verilog/player_ctrl.sv
verilog/bullet_unit.sv
verilog/enemy_field.sv
verilog/status_digits.sv
verilog/game_top.sv
sim/game_tb.sv

//--- sim/game_tests.svh
`ifndef GAME_TESTS_SVH
`define GAME_TESTS_SVH

// ========================================
// key and player model helpers
// ========================================
task automatic drive_key(input int key, input logic level);
    case (key)
        0: key_w = level;
        1: key_a = level;
        2: key_s = level;
        default: key_d = level;
    endcase
endtask

// player stays at least one step away from every screen edge
task automatic step_model(input int key);
    case (key)
        0: if (exp_py >= 2 * `PLAYER_STEP) exp_py = exp_py - `PLAYER_STEP;
        1: if (exp_px >= 2 * `PLAYER_STEP) exp_px = exp_px - `PLAYER_STEP;
        2: if (exp_py + `PLAYER_STEP <= `SCREEN_H - `PLAYER_STEP) exp_py = exp_py + `PLAYER_STEP;
        default: if (exp_px + `PLAYER_STEP <= `SCREEN_W - `PLAYER_STEP) exp_px = exp_px + `PLAYER_STEP;
    endcase
endtask

// press, hold one more cycle and release
task automatic press_key(input int key);
    drive_key(key, 1'b1);
    step_model(key);
    next_cycle();
    check_coord("player step x", exp_px, player_x);
    check_coord("player step y", exp_py, player_y);
    next_cycle();                  // key still held
    check_coord("player held x", exp_px, player_x);
    check_coord("player held y", exp_py, player_y);
    drive_key(key, 1'b0);
    next_cycle();
endtask

// repeat one key until a press no longer moves the model
task automatic press_to_edge(input int key);
    game_pkg::coord_t last_px, last_py;
    do begin
        last_px = exp_px;
        last_py = exp_py;
        press_key(key);
    end while (last_px != exp_px || last_py != exp_py);
endtask

task automatic press_start();
    btn_start = 1'b1;
    next_cycle();
    btn_start = 1'b0;
endtask

// ========================================
// directed tests
// ========================================
task automatic test_reset();
    next_cycle();
    check_state("reset state", game_pkg::MENU_IDLE, state);
    check_bit("reset menu_sel", 1'b0, menu_sel);
    check_bit("reset bullet", 1'b0, bullet_active);
    check_count("reset health", `START_HEALTH, health);
    check_status("reset status", {4'd5, 4'd0, 4'd0, 4'd0}, status);
endtask

task automatic test_menu();
    btn_down = 1'b1;
    next_cycle();
    btn_down = 1'b0;
    check_bit("menu down", 1'b1, menu_sel);
    press_start();
    check_state("menu tutorial", game_pkg::MENU_TUTORIAL, state);
    btn_back = 1'b1;
    next_cycle();
    btn_back = 1'b0;
    check_state("menu back", game_pkg::MENU_IDLE, state);
    btn_up = 1'b1;
    next_cycle();
    btn_up = 1'b0;
    check_bit("menu up", 1'b0, menu_sel);
    press_start();
    check_state("menu start", game_pkg::GAME_RUNNING, state);
endtask

task automatic test_player();
    check_coord("player start x", exp_px, player_x);
    check_coord("player start y", exp_py, player_y);
    for (int k = 0; k < 4; k++) begin
        press_to_edge(k);              // top, left, bottom, right edge
    end
    while (exp_px > `PLAYER_X0) press_key(1);
    while (exp_py > `PLAYER_Y0) press_key(0);
    for (int n = 0; n < 12; n++) begin
        press_key($urandom_range(3, 0));
    end
endtask

task automatic test_bullet();
    game_pkg::velocity_t dx, dy;
    game_pkg::coord_t    last_x, last_y;
    game_pkg::count_t    score0;
    int                  t, nx, ny;
    dx = game_pkg::velocity_t'($urandom_range(31, 8));
    if ($urandom_range(1, 0) == 1) dx = -dx;
    dy = game_pkg::velocity_t'(int'($urandom_range(16, 0)) - 8);
    aim_dx = dx;
    aim_dy = dy;
    fire   = 1'b1;                     // held for the whole flight
    score0 = score;
    t = 0;
    while (!bullet_active) begin
        next_cycle();
        t++;
        if (t > 20) fail_run("timeout: the bullet did not launch after fire");
    end
    check_coord("bullet launch x", exp_px, bullet_x);
    check_coord("bullet launch y", exp_py, bullet_y);
    last_x = bullet_x;
    last_y = bullet_y;
    t = 0;
    while (bullet_active) begin
        next_cycle();
        t++;
        if (t > 1000) fail_run("timeout: the bullet never left the screen");
        if (bullet_x != last_x || bullet_y != last_y) begin
            check_coord("bullet move x", game_pkg::coord_t'(int'(last_x) + int'(dx)), bullet_x);
            check_coord("bullet move y", game_pkg::coord_t'(int'(last_y) + int'(dy)), bullet_y);
            last_x = bullet_x;
            last_y = bullet_y;
        end
    end
    fire = 1'b0;
    nx = int'(last_x) + int'(dx);
    ny = int'(last_y) + int'(dy);
    if (score == score0 && nx >= 0 && nx <= `SCREEN_W - `BULLET_W
            && ny >= 0 && ny <= `SCREEN_H - `BULLET_H) begin
        fail_run("the bullet ended inside the screen without hitting an enemy");
    end
endtask

task automatic test_win();
    game_pkg::count_t last_score;
    logic             was_active;
    int               t;
    aim_dx     = game_pkg::velocity_t'($urandom_range(31, 20));
    aim_dy     = '0;
    fire       = 1'b1;
    last_score = score;
    was_active = bullet_active;
    t = 0;
    while (score < `WIN_SCORE) begin
        next_cycle();
        t++;
        if (t > 300000) fail_run("timeout: the score never reached the win score");
        check_state("win running", game_pkg::GAME_RUNNING, state);
        if (score != last_score) check_count("win score step", last_score + 1'b1, score);
        check_status("win status", digits_of(health, score), status);
        if (was_active && !bullet_active) aim_dx = -aim_dx; // alternate sides
        was_active = bullet_active;
        last_score = score;
    end
    fire = 1'b0;
    next_cycle();
    check_state("win state", game_pkg::GAME_WIN, state);
    next_cycle();
    check_count("win score clear", 8'd0, score);
    press_start();
    check_state("win to menu", game_pkg::MENU_IDLE, state);
endtask

task automatic test_game_over();
    game_pkg::count_t last_health;
    int               t;
    press_start();
    check_state("over start", game_pkg::GAME_RUNNING, state);
    check_count("over health start", `START_HEALTH, health);
    last_health = health;
    t = 0;
    while (health != 0) begin
        next_cycle();
        t++;
        if (t > 300000) fail_run("timeout: health never reached zero");
        check_state("over running", game_pkg::GAME_RUNNING, state);
        if (health > last_health || (last_health - health) % `HIT_DAMAGE != 0) begin
            check_count("over health step", last_health - `HIT_DAMAGE, health);
        end
        check_status("over status", digits_of(health, score), status);
        last_health = health;
    end
    next_cycle();
    check_state("over state", game_pkg::GAME_OVER, state);
    press_start();
    check_state("over to menu", game_pkg::MENU_IDLE, state);
    check_count("over menu health", `START_HEALTH, health);
endtask

`endif

//--- sim/game_tb.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module game_tb;

    logic                       clk, rst;
    logic                       btn_up, btn_down, btn_start, btn_back;
    logic                       key_w, key_a, key_s, key_d, fire;
    game_pkg::velocity_t        aim_dx, aim_dy;
    game_pkg::game_state_t      state;
    logic                       menu_sel, bullet_active;
    game_pkg::coord_t           player_x, player_y, bullet_x, bullet_y;
    game_pkg::count_t           score, health;
    game_pkg::bcd_digit_t [3:0] status;

    game_pkg::coord_t exp_px, exp_py; // player position model
    int               errors = 0;
    int               seed;

    game_top uut (
        .clk(clk), .rst(rst),
        .btn_up(btn_up), .btn_down(btn_down), .btn_start(btn_start), .btn_back(btn_back),
        .key_w(key_w), .key_a(key_a), .key_s(key_s), .key_d(key_d),
        .fire(fire), .aim_dx(aim_dx), .aim_dy(aim_dy),
        .state(state), .menu_sel(menu_sel), .player_x(player_x), .player_y(player_y),
        .bullet_active(bullet_active), .bullet_x(bullet_x), .bullet_y(bullet_y),
        .score(score), .health(health), .status(status)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ========================================
    // helpers and compare tasks
    // ========================================
    task automatic next_cycle();
        @(negedge clk); // outputs settled, inputs change here
    endtask

    task automatic fail_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_state(input string name, input game_pkg::game_state_t exp,
                               input game_pkg::game_state_t act);
        if (act !== exp) fail_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) fail_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_coord(input string name, input game_pkg::coord_t exp,
                               input game_pkg::coord_t act);
        if (act !== exp) fail_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_count(input string name, input game_pkg::count_t exp,
                               input game_pkg::count_t act);
        if (act !== exp) fail_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_status(input string name, input game_pkg::bcd_digit_t [3:0] exp,
                                input game_pkg::bcd_digit_t [3:0] act);
        if (act !== exp) fail_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    // health tens, health ones, score tens, score ones
    function automatic logic [15:0] digits_of(input int h, input int s);
        return {4'(h / 10), 4'(h % 10), 4'(s / 10), 4'(s % 10)};
    endfunction

    `include "game_tests.svh"

    initial begin
        seed      = $urandom(32'h84ea);
        rst       = 1'b1;
        btn_up    = 1'b0;
        btn_down  = 1'b0;
        btn_start = 1'b0;
        btn_back  = 1'b0;
        key_w     = 1'b0;
        key_a     = 1'b0;
        key_s     = 1'b0;
        key_d     = 1'b0;
        fire      = 1'b0;
        aim_dx    = '0;
        aim_dy    = '0;
        exp_px    = game_pkg::coord_t'(`PLAYER_X0);
        exp_py    = game_pkg::coord_t'(`PLAYER_Y0);
        repeat (16) @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_menu();
        test_player();
        test_bullet();
        test_win();
        test_game_over();

        if (errors == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            fail_run("one or more checks failed during the run");
        end
    end

endmodule

//--- verilog/bullet_unit.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module bullet_unit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 bullet_tick,
    input  logic                                 playing,
    input  logic                                 fire,
    input  game_pkg::velocity_t                  aim_dx,
    input  game_pkg::velocity_t                  aim_dy,
    input  game_pkg::game_state_t                state,
    input  game_pkg::coord_t                     player_x,
    input  game_pkg::coord_t                     player_y,
    input  game_pkg::enemy_mask_t                enemy_active,
    input  game_pkg::scoord_t [`MAX_ENEMIES-1:0] enemy_x,
    input  game_pkg::coord_t  [`MAX_ENEMIES-1:0] enemy_y,
    output logic                                 bullet_active,
    output game_pkg::coord_t                     bullet_x,
    output game_pkg::coord_t                     bullet_y,
    output game_pkg::enemy_mask_t                hit_mask,
    output game_pkg::count_t                     score
);
    game_pkg::velocity_t   vel_x, vel_y;
    game_pkg::enemy_mask_t overlap, first_hit;
    logic signed [11:0]    bx, next_x, next_y;
    logic                  out_of_bounds, clear_score, scored;

    assign bx = $signed({2'b00, bullet_x});

    // ========================================
    // box test against every active enemy
    // ========================================
    always_comb begin
        for (int i = 0; i < `MAX_ENEMIES; i++) begin
            overlap[i] = enemy_active[i]
                && (bx + `BULLET_W > enemy_x[i])
                && (bx < enemy_x[i] + `SPRITE_SIZE)
                && (bullet_y + `BULLET_H > enemy_y[i])
                && (bullet_y < enemy_y[i] + `SPRITE_SIZE);
        end
    end

    assign first_hit = overlap & (~overlap + 1'b1); // lowest slot wins

    assign next_x = bx + vel_x;
    assign next_y = $signed({2'b00, bullet_y}) + vel_y;
    assign out_of_bounds = (next_x < 0) || (next_x > `SCREEN_W - `BULLET_W)
                        || (next_y < 0) || (next_y > `SCREEN_H - `BULLET_H);

    assign clear_score = (state == game_pkg::MENU_IDLE) || (state == game_pkg::MENU_TUTORIAL)
                      || (state == game_pkg::GAME_WIN);
    assign scored = playing && bullet_tick && bullet_active && (|first_hit);

    // ========================================
    // bullet life cycle
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bullet_active <= 1'b0;
            bullet_x      <= '0;
            bullet_y      <= '0;
            vel_x         <= '0;
            vel_y         <= '0;
            hit_mask      <= '0;
        end else if (!playing) begin
            bullet_active <= 1'b0;
            hit_mask      <= '0;
        end else if (bullet_tick) begin
            hit_mask <= '0; // a hit flag lasts one tick period
            if (!bullet_active) begin
                if (fire && (aim_dx != '0 || aim_dy != '0)) begin
                    bullet_active <= 1'b1;
                    bullet_x      <= player_x;
                    bullet_y      <= player_y;
                    vel_x         <= aim_dx;
                    vel_y         <= aim_dy;
                end
            end else if (|first_hit) begin
                bullet_active <= 1'b0;
                hit_mask      <= first_hit;
            end else if (out_of_bounds) begin
                bullet_active <= 1'b0;
            end else begin
                bullet_x <= game_pkg::coord_t'(next_x);
                bullet_y <= game_pkg::coord_t'(next_y);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            score <= '0;
        end else if (clear_score) begin
            score <= '0;
        end else if (scored && score < `WIN_SCORE) begin
            score <= score + 1'b1;
        end
    end

endmodule

//--- verilog/enemy_field.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module enemy_field (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 enemy_tick,
    input  logic                                 playing,
    input  game_pkg::enemy_mask_t                hit_mask,
    input  game_pkg::coord_t                     player_x,
    input  game_pkg::coord_t                     player_y,
    output game_pkg::enemy_mask_t                enemy_active,
    output game_pkg::scoord_t [`MAX_ENEMIES-1:0] enemy_x,
    output game_pkg::coord_t  [`MAX_ENEMIES-1:0] enemy_y,
    output game_pkg::count_t                     health
);
    localparam int SPAWN_LEFT  = -`SPAWN_MARGIN;
    localparam int SPAWN_RIGHT = `SCREEN_W + `SPAWN_MARGIN;

    logic [9:0]                           lfsr;
    game_pkg::enemy_mask_t                alive, moving_right, pending, kill;
    game_pkg::enemy_mask_t                collide, empty, spawn_slot;
    game_pkg::scoord_t [`MAX_ENEMIES-1:0] next_x;
    game_pkg::count_t                     damage;
    logic signed [11:0]                   px;

    // hits arrive on the bullet tick, held here until the next enemy tick
    assign kill         = pending | hit_mask;
    assign enemy_active = alive & ~kill;

    assign empty      = ~alive;
    assign spawn_slot = empty & (~empty + 1'b1); // one new enemy per tick
    assign px         = $signed({2'b00, player_x});

    // ========================================
    // per-slot motion and player collision
    // ========================================
    always_comb begin
        damage = '0;
        for (int i = 0; i < `MAX_ENEMIES; i++) begin
            next_x[i] = moving_right[i] ? enemy_x[i] + game_pkg::scoord_t'(`ENEMY_SPEED)
                                        : enemy_x[i] - game_pkg::scoord_t'(`ENEMY_SPEED);
            collide[i] = alive[i] && !kill[i]
                && (enemy_x[i] + `SPRITE_SIZE > px)
                && (enemy_x[i] < px + `SPRITE_SIZE)
                && (enemy_y[i] + `SPRITE_SIZE > player_y)
                && (enemy_y[i] < player_y + `SPRITE_SIZE);
            if (collide[i]) damage = damage + game_pkg::count_t'(`HIT_DAMAGE);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr         <= `LFSR_SEED;
            alive        <= '0;
            moving_right <= '0;
            pending      <= '0;
            enemy_x      <= '0;
            enemy_y      <= '0;
            health       <= game_pkg::count_t'(`START_HEALTH);
        end else begin
            if (enemy_tick) begin
                lfsr <= {lfsr[8:0], lfsr[9] ^ lfsr[6]}; // x^10 + x^7 + 1
            end
            if (!playing) begin
                alive   <= '0;
                pending <= '0;
                health  <= game_pkg::count_t'(`START_HEALTH);
            end else if (!enemy_tick) begin
                pending <= kill;
            end else begin
                pending <= '0;
                health  <= (health > damage) ? health - damage : '0;
                for (int i = 0; i < `MAX_ENEMIES; i++) begin
                    if (kill[i] || collide[i]) begin
                        alive[i] <= 1'b0;
                    end else if (alive[i]) begin
                        enemy_x[i] <= next_x[i];
                        if (next_x[i] < SPAWN_LEFT || next_x[i] > SPAWN_RIGHT) begin
                            alive[i] <= 1'b0;  // crossed the far margin
                        end
                    end else if (spawn_slot[i]) begin
                        alive[i]        <= 1'b1;
                        moving_right[i] <= lfsr[0];
                        enemy_x[i]      <= lfsr[0] ? game_pkg::scoord_t'(SPAWN_LEFT)
                                                   : game_pkg::scoord_t'(SPAWN_RIGHT);
                        enemy_y[i]      <= game_pkg::coord_t'(lfsr % (`SCREEN_H - `SPRITE_SIZE));
                    end
                end
            end
        end
    end

endmodule

//--- verilog/game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// playfield and sprite geometry in pixels
`define SCREEN_W        640
`define SCREEN_H        480
`define SPRITE_SIZE     20
`define BULLET_W        5
`define BULLET_H        10

// player
`define PLAYER_STEP     5
`define PLAYER_X0       320
`define PLAYER_Y0       240

// enemies
`define MAX_ENEMIES     4
`define ENEMY_SPEED     10
`define SPAWN_MARGIN    20     // start and removal distance off-screen

// game rules
`define WIN_SCORE       10
`define START_HEALTH    50
`define HIT_DAMAGE      5

// tick periods in clk cycles
`define BULLET_TICK_DIV 4
`define ENEMY_TICK_DIV  16

`define LFSR_SEED       10'h2AA  // must be nonzero

`endif

//--- verilog/game_fsm.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module game_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  btn_up,
    input  logic                  btn_down,
    input  logic                  btn_start,
    input  logic                  btn_back,
    input  game_pkg::count_t      score,
    input  game_pkg::count_t      health,
    output game_pkg::game_state_t state,
    output logic                  menu_sel,   // 0 start game, 1 tutorial
    output logic                  playing
);
    game_pkg::game_state_t next_state;

    // ========================================
    // transitions
    // ========================================
    always_comb begin
        next_state = state;
        case (state)
            game_pkg::MENU_IDLE: begin
                if (btn_start) begin
                    next_state = menu_sel ? game_pkg::MENU_TUTORIAL : game_pkg::GAME_RUNNING;
                end
            end
            game_pkg::MENU_TUTORIAL: begin
                if (btn_back) next_state = game_pkg::MENU_IDLE;
            end
            game_pkg::GAME_RUNNING: begin
                if (score >= `WIN_SCORE) begin
                    next_state = game_pkg::GAME_WIN;
                end else if (health == '0) begin
                    next_state = game_pkg::GAME_OVER;
                end
            end
            game_pkg::GAME_OVER, game_pkg::GAME_WIN: begin
                if (btn_start) next_state = game_pkg::MENU_IDLE;
            end
            default: next_state = game_pkg::MENU_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= game_pkg::MENU_IDLE;
            playing  <= 1'b0;
            menu_sel <= 1'b0;
        end else begin
            state   <= next_state;
            playing <= (next_state == game_pkg::GAME_RUNNING);
            if (state == game_pkg::MENU_IDLE) begin
                if (btn_up) menu_sel <= 1'b0;
                else if (btn_down) menu_sel <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/game_pkg.sv
`include "game_defines.svh"

package game_pkg;

    typedef enum logic [2:0] {
        MENU_IDLE,
        MENU_TUTORIAL,
        GAME_RUNNING,
        GAME_OVER,
        GAME_WIN
    } game_state_t;

    typedef logic [9:0] coord_t;           // on-screen position
    typedef logic signed [10:0] scoord_t;  // may lie off-screen
    typedef logic signed [5:0] velocity_t; // pixels per tick

    typedef logic [`MAX_ENEMIES-1:0] enemy_mask_t;

    typedef logic [7:0] count_t;    // score or health
    typedef logic [3:0] bcd_digit_t;

endpackage

//--- verilog/game_top.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module game_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       btn_up,
    input  logic                       btn_down,
    input  logic                       btn_start,
    input  logic                       btn_back,
    input  logic                       key_w,
    input  logic                       key_a,
    input  logic                       key_s,
    input  logic                       key_d,
    input  logic                       fire,
    input  game_pkg::velocity_t        aim_dx,
    input  game_pkg::velocity_t        aim_dy,
    output game_pkg::game_state_t      state,
    output logic                       menu_sel,
    output game_pkg::coord_t           player_x,
    output game_pkg::coord_t           player_y,
    output logic                       bullet_active,
    output game_pkg::coord_t           bullet_x,
    output game_pkg::coord_t           bullet_y,
    output game_pkg::count_t           score,
    output game_pkg::count_t           health,
    output game_pkg::bcd_digit_t [3:0] status
);
    logic                                 bullet_tick, enemy_tick, playing;
    game_pkg::enemy_mask_t                enemy_active, hit_mask;
    game_pkg::scoord_t [`MAX_ENEMIES-1:0] enemy_x;
    game_pkg::coord_t  [`MAX_ENEMIES-1:0] enemy_y;

    // ========================================
    // rate ticks
    // ========================================
    tick_divider #(.DIV(`BULLET_TICK_DIV)) u_bullet_tick (
        .clk(clk), .rst(rst), .tick(bullet_tick)
    );

    tick_divider #(.DIV(`ENEMY_TICK_DIV)) u_enemy_tick (
        .clk(clk), .rst(rst), .tick(enemy_tick)
    );

    game_fsm u_fsm (
        .clk(clk), .rst(rst),
        .btn_up(btn_up), .btn_down(btn_down), .btn_start(btn_start), .btn_back(btn_back),
        .score(score), .health(health),
        .state(state), .menu_sel(menu_sel), .playing(playing)
    );

    player_ctrl u_player (
        .clk(clk), .rst(rst), .playing(playing),
        .key_w(key_w), .key_a(key_a), .key_s(key_s), .key_d(key_d),
        .player_x(player_x), .player_y(player_y)
    );

    bullet_unit u_bullet (
        .clk(clk), .rst(rst), .bullet_tick(bullet_tick), .playing(playing), .fire(fire),
        .aim_dx(aim_dx), .aim_dy(aim_dy), .state(state),
        .player_x(player_x), .player_y(player_y),
        .enemy_active(enemy_active), .enemy_x(enemy_x), .enemy_y(enemy_y),
        .bullet_active(bullet_active), .bullet_x(bullet_x), .bullet_y(bullet_y),
        .hit_mask(hit_mask), .score(score)
    );

    enemy_field u_enemies (
        .clk(clk), .rst(rst), .enemy_tick(enemy_tick), .playing(playing),
        .hit_mask(hit_mask), .player_x(player_x), .player_y(player_y),
        .enemy_active(enemy_active), .enemy_x(enemy_x), .enemy_y(enemy_y),
        .health(health)
    );

    status_digits u_status (
        .health(health), .score(score), .status(status)
    );

endmodule

//--- verilog/player_ctrl.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module player_ctrl (
    input  logic             clk,
    input  logic             rst,
    input  logic             playing,
    input  logic             key_w,
    input  logic             key_a,
    input  logic             key_s,
    input  logic             key_d,
    output game_pkg::coord_t player_x,
    output game_pkg::coord_t player_y
);
    localparam game_pkg::coord_t STEP  = game_pkg::coord_t'(`PLAYER_STEP);
    localparam game_pkg::coord_t MAX_X = game_pkg::coord_t'(`SCREEN_W - `PLAYER_STEP);
    localparam game_pkg::coord_t MAX_Y = game_pkg::coord_t'(`SCREEN_H - `PLAYER_STEP);

    logic prev_w, prev_a, prev_s, prev_d;
    logic rise_w, rise_a, rise_s, rise_d;

    // one step per press, held keys do not repeat
    assign rise_w = key_w & ~prev_w;
    assign rise_a = key_a & ~prev_a;
    assign rise_s = key_s & ~prev_s;
    assign rise_d = key_d & ~prev_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prev_w   <= 1'b0;
            prev_a   <= 1'b0;
            prev_s   <= 1'b0;
            prev_d   <= 1'b0;
            player_x <= game_pkg::coord_t'(`PLAYER_X0);
            player_y <= game_pkg::coord_t'(`PLAYER_Y0);
        end else begin
            prev_w <= key_w;
            prev_a <= key_a;
            prev_s <= key_s;
            prev_d <= key_d;
            if (!playing) begin
                player_x <= game_pkg::coord_t'(`PLAYER_X0);
                player_y <= game_pkg::coord_t'(`PLAYER_Y0);
            end else begin
                if (rise_w && player_y > STEP) player_y <= player_y - STEP;
                else if (rise_s && player_y < MAX_Y) player_y <= player_y + STEP;
                if (rise_a && player_x > STEP) player_x <= player_x - STEP;
                else if (rise_d && player_x < MAX_X) player_x <= player_x + STEP;
            end
        end
    end

endmodule

//--- verilog/status_digits.sv
`timescale 1ns/1ps

module status_digits (
    input  game_pkg::count_t           health,
    input  game_pkg::count_t           score,
    output game_pkg::bcd_digit_t [3:0] status
);
    game_pkg::bcd_digit_t health_tens, health_ones;
    game_pkg::bcd_digit_t score_tens, score_ones;

    // both counts stay below 100
    assign health_tens = game_pkg::bcd_digit_t'(health / 8'd10);
    assign health_ones = game_pkg::bcd_digit_t'(health % 8'd10);
    assign score_tens  = game_pkg::bcd_digit_t'(score / 8'd10);
    assign score_ones  = game_pkg::bcd_digit_t'(score % 8'd10);

    assign status = {health_tens, health_ones, score_tens, score_ones};

endmodule

//--- verilog/tick_divider.sv
`timescale 1ns/1ps

module tick_divider #(
    parameter int DIV = 4
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);
    localparam int W = $clog2(DIV);
    localparam logic [W-1:0] LAST = W'(DIV - 1);

    logic [W-1:0] cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            cnt  <= (cnt == LAST) ? '0 : cnt + 1'b1;
            tick <= (cnt == LAST); // high for one cycle per wrap
        end
    end

endmodule
